// ==== compile.f ====
+incdir+include
src/isa_pkg.sv
src/decode_pkg.sv
src/special_decode.sv
src/imm_decode.sv
src/branch_decode.sv
src/decode_stage.sv
tb/tb_clock.sv
tb/decode_stage_tb.sv

// ==== run.sh ====
#!/bin/bash
# Build and run the decode stage testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log build.log

verilator --binary --timing --assert --top-module decode_stage_tb \
    -f compile.f -o decode_stage_sim > build.log 2>&1 \
    || { echo "Verilator build failed, see build.log"; exit 1; }

./obj_dir/decode_stage_sim 2>&1 | tee sim.log

grep -q "TEST RESULT: PASS" sim.log \
    && { echo "Simulation passed"; exit 0; } \
    || { echo "Simulation failed, see sim.log"; exit 1; }

// ==== tb/decode_stage_tb.sv ====
`timescale 1ns/1ps
`include "mips_defs.svh"

module decode_stage_tb
    import isa_pkg::*;
    import decode_pkg::*;
();

    localparam int MAX_CYCLES   = 2000;
    localparam int RESET_CYCLES = 8;

    logic           clk;
    logic           rst_n;
    word_t          instr;
    logic           instr_valid;
    decode_result_t dec;
    logic           dec_valid;

    int             errors;
    int             checks;
    int             cycles;
    logic [31:0]    rng_state = 32'h3ac7e19b;
    decode_result_t pend_exp;
    string          pend_label;
    logic           have_pending;

    tb_clock #(.PERIOD_NS(20), .RESET_CYCLES(RESET_CYCLES)) u_clock (
        .clk   (clk),
        .rst_n (rst_n)
    );

    decode_stage dut0 (
        .clk         (clk),
        .rst_n       (rst_n),
        .instr       (instr),
        .instr_valid (instr_valid),
        .dec         (dec),
        .dec_valid   (dec_valid)
    );

    function automatic logic [31:0] next_random();
        rng_state = rng_state ^ (rng_state << 13);
        rng_state = rng_state ^ (rng_state >> 17);
        rng_state = rng_state ^ (rng_state << 5);
        return rng_state;
    endfunction

    function automatic reg_addr_t rand_reg();
        logic [31:0] r;
        r = next_random();
        return r[`REG_ADDR_W-1:0];
    endfunction

    task automatic check_valid(input logic act, input logic exp, input string label);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("[ERROR] %0t dec_valid (%s): got %b, expected %b", $time, label, act, exp);
        end
    endtask

    task automatic check_result(input decode_result_t act, input decode_result_t exp,
                                input string label);
        checks++;
        if (act !== exp) begin
            errors++;
            if (act.op !== exp.op)
                $display("[ERROR] %0t dec.op (%s): got %s, expected %s",
                         $time, label, act.op.name(), exp.op.name());
            if (act.ctl !== exp.ctl)
                $display("[ERROR] %0t dec.ctl (%s): got %h, expected %h",
                         $time, label, act.ctl, exp.ctl);
            if ({act.srcrega, act.srcregb, act.destreg} !==
                {exp.srcrega, exp.srcregb, exp.destreg})
                $display("[ERROR] %0t dec.srcrega/srcregb/destreg (%s): got %0d/%0d/%0d, %s",
                         $time, label, act.srcrega, act.srcregb, act.destreg,
                         $sformatf("expected %0d/%0d/%0d",
                                   exp.srcrega, exp.srcregb, exp.destreg));
            if (act.exception_ri !== exp.exception_ri)
                $display("[ERROR] %0t dec.exception_ri (%s): got %b, expected %b",
                         $time, label, act.exception_ri, exp.exception_ri);
        end
    endtask

    // The result of the previous instruction is visible while this one is driven
    task automatic issue(input word_t w, input decode_result_t exp, input string label);
        @(posedge clk);
        instr <= w;
        instr_valid <= 1'b1;
        @(negedge clk);
        if (have_pending) begin
            check_valid(dec_valid, 1'b1, pend_label);
            check_result(dec, pend_exp, pend_label);
        end
        pend_exp = exp;
        pend_label = label;
        have_pending = 1'b1;
    endtask

    task automatic drain();
        @(posedge clk);
        instr <= next_random();
        instr_valid <= 1'b0;
        @(negedge clk);
        check_valid(dec_valid, 1'b1, pend_label);
        check_result(dec, pend_exp, pend_label);
        have_pending = 1'b0;
        // Idle cycle drops valid and holds the last result
        @(posedge clk);
        @(negedge clk);
        check_valid(dec_valid, 1'b0, "idle");
        check_result(dec, pend_exp, "idle hold");
    endtask

    task automatic special_case(input logic [5:0] funct, input decoded_op_e op,
                                input alu_func_e af);
        reg_addr_t      rs;
        reg_addr_t      rt;
        reg_addr_t      rd;
        logic [4:0]     shamt;
        decode_result_t exp;
        rs = rand_reg();
        rt = rand_reg();
        rd = rand_reg();
        shamt = rand_reg();
        exp = '0;
        exp.op = op;
        exp.ctl.alufunc = af;
        if (op inside {JR, JALR}) begin
            exp.srcrega = rs;
            exp.ctl.jump = 1'b1;
            exp.ctl.jr = 1'b1;
            if (op == JALR) begin
                exp.ctl.regwrite = 1'b1;
                exp.ctl.is_link = 1'b1;
                exp.destreg = reg_addr_t'(`LINK_REG);
            end
        end else begin
            exp.srcrega = (op inside {SLL, SRL, SRA}) ? '0 : rs;
            exp.srcregb = rt;
            exp.destreg = rd;
            exp.ctl.alusrc = REGB;
            exp.ctl.regwrite = 1'b1;
            exp.ctl.shamt_valid = op inside {SLL, SRL, SRA};
            exp.ctl.delayen = !(op inside {ADD, SUB});
        end
        issue({6'h00, rs, rt, rd, shamt, funct}, exp, op.name());
    endtask

    task automatic imm_case(input logic [5:0] opc, input decoded_op_e op, input alu_func_e af);
        reg_addr_t      rs;
        reg_addr_t      rt;
        logic [31:0]    r;
        decode_result_t exp;
        rs = rand_reg();
        rt = rand_reg();
        r = next_random();
        exp = '0;
        exp.op = op;
        exp.ctl.alusrc = IMM;
        exp.srcrega = (op == LUI) ? '0 : rs;
        if (op inside {SB, SH, SW}) begin
            exp.srcregb = rt;
            exp.ctl.memwrite = 1'b1;
        end else begin
            exp.destreg = rt;
            exp.ctl.regwrite = 1'b1;
            exp.ctl.memtoreg = op inside {LB, LBU, LH, LHU, LW};
            exp.ctl.alufunc = af;
            exp.ctl.zeroext = op inside {ANDI, ORI, XORI};
            exp.ctl.delayen = !(op inside {ADDI, LB, LBU, LH, LHU, LW});
        end
        issue({opc, rs, rt, r[15:0]}, exp, op.name());
    endtask

    task automatic branch_case(input logic [5:0] opc, input logic [4:0] sel,
                               input decoded_op_e op, input branch_type_e bt);
        word_t          w;
        decode_result_t exp;
        w = next_random();
        w[`OPCODE_HI:`OPCODE_LO] = opc;
        if (opc == 6'h01) w[`RT_HI:`RT_LO] = sel;
        exp = '0;
        exp.op = op;
        exp.ctl.branch_type = bt;
        if (op inside {J, JAL}) begin
            exp.ctl.jump = 1'b1;
        end else begin
            exp.srcrega = w[`RS_HI:`RS_LO];
            exp.ctl.branch = 1'b1;
            if (op inside {BEQ, BNE}) begin
                exp.srcregb = w[`RT_HI:`RT_LO];
                exp.ctl.branch2 = 1'b1;
            end else begin
                exp.ctl.branch1 = 1'b1;
            end
        end
        if (op inside {JAL, BGEZAL, BLTZAL}) begin
            exp.ctl.regwrite = 1'b1;
            exp.ctl.is_link = 1'b1;
            exp.destreg = reg_addr_t'(`LINK_REG);
        end
        issue(w, exp, op.name());
    endtask

    task automatic reserved_case(input logic [5:0] opc, input logic [5:0] sel);
        word_t          w;
        decode_result_t exp;
        w = next_random();
        w[`OPCODE_HI:`OPCODE_LO] = opc;
        if (opc == 6'h00) w[`FUNCT_HI:`FUNCT_LO] = sel;
        if (opc == 6'h01) w[`RT_HI:`RT_LO] = sel[4:0];
        exp = '0;
        exp.op = RESERVED;
        exp.ctl.alufunc = ALU_PASSA;
        exp.exception_ri = 1'b1;
        issue(w, exp, $sformatf("reserved %h", w));
    endtask

    // A valid instruction is held through reset and must not reach the output
    task automatic reset_behavior();
        for (int i = 0; i < RESET_CYCLES; i++) begin
            @(posedge clk);
            if (i == RESET_CYCLES - 1) begin
                instr_valid <= 1'b0;
            end
            @(negedge clk);
            check_valid(dec_valid, 1'b0, "in reset");
            check_result(dec, '0, "in reset");
        end
        if (rst_n !== 1'b1) begin
            errors++;
            $display("Reset was not released after %0d cycles", RESET_CYCLES);
        end
        @(negedge clk);
        check_valid(dec_valid, 1'b0, "after reset");
        check_result(dec, '0, "after reset");
        special_case(6'h21, ADDU, ALU_ADDU);
        drain();
    endtask

    // Driven back-to-back so a result appears every cycle
    task automatic special_ops();
        special_case(6'h20, ADD, ALU_ADD);
        special_case(6'h21, ADDU, ALU_ADDU);
        special_case(6'h22, SUB, ALU_SUB);
        special_case(6'h23, SUBU, ALU_SUBU);
        special_case(6'h2a, SLT, ALU_SLT);
        special_case(6'h2b, SLTU, ALU_SLTU);
        special_case(6'h24, AND, ALU_AND);
        special_case(6'h25, OR, ALU_OR);
        special_case(6'h26, XOR, ALU_XOR);
        special_case(6'h27, NOR, ALU_NOR);
        special_case(6'h00, SLL, ALU_SLL);
        special_case(6'h02, SRL, ALU_SRL);
        special_case(6'h03, SRA, ALU_SRA);
        special_case(6'h04, SLLV, ALU_SLL);
        special_case(6'h06, SRLV, ALU_SRL);
        special_case(6'h07, SRAV, ALU_SRA);
        special_case(6'h08, JR, ALU_PASSA);
        special_case(6'h09, JALR, ALU_PASSA);
        drain();
    endtask

    task automatic immediate_ops();
        imm_case(6'h08, ADDI, ALU_ADD);
        imm_case(6'h09, ADDIU, ALU_ADDU);
        imm_case(6'h0a, SLTI, ALU_SLT);
        imm_case(6'h0b, SLTIU, ALU_SLTU);
        imm_case(6'h0c, ANDI, ALU_AND);
        imm_case(6'h0d, ORI, ALU_OR);
        imm_case(6'h0e, XORI, ALU_XOR);
        imm_case(6'h0f, LUI, ALU_LUI);
        imm_case(6'h20, LB, ALU_PASSA);
        imm_case(6'h24, LBU, ALU_PASSA);
        imm_case(6'h21, LH, ALU_PASSA);
        imm_case(6'h25, LHU, ALU_PASSA);
        imm_case(6'h23, LW, ALU_PASSA);
        imm_case(6'h28, SB, ALU_PASSA);
        imm_case(6'h29, SH, ALU_PASSA);
        imm_case(6'h2b, SW, ALU_PASSA);
        drain();
    endtask

    task automatic branch_ops();
        branch_case(6'h04, 5'h00, BEQ, T_BEQ);
        branch_case(6'h05, 5'h00, BNE, T_BNE);
        branch_case(6'h01, 5'h01, BGEZ, T_BGEZ);
        branch_case(6'h01, 5'h00, BLTZ, T_BLTZ);
        branch_case(6'h01, 5'h11, BGEZAL, T_BGEZ);
        branch_case(6'h01, 5'h10, BLTZAL, T_BLTZ);
        branch_case(6'h07, 5'h00, BGTZ, T_BGTZ);
        branch_case(6'h06, 5'h00, BLEZ, T_BLEZ);
        branch_case(6'h02, 5'h00, J, T_NONE);
        branch_case(6'h03, 5'h00, JAL, T_NONE);
        drain();
    endtask

    task automatic reserved_ops();
        // Opcode in the upper six bits, function or REGIMM rt in the lower six
        logic [11:0] codes [18];
        codes = '{12'h018, 12'h01a, 12'h010, 12'h013, 12'h00a, 12'h00c, 12'h00d,
                  12'h03f, 12'h001, 12'h042, 12'h05f, 12'h400, 12'h700, 12'hc00,
                  12'he00, 12'h880, 12'hbc0, 12'hfc0};
        foreach (codes[i]) reserved_case(codes[i][11:6], codes[i][5:0]);
        drain();
    endtask

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= MAX_CYCLES) begin
            $display("Simulation timed out after %0d cycles", cycles);
            $display("TEST RESULT: FAIL");
            $finish;
        end
    end

    initial begin
        // ADDU r3, r1, r2 offered during reset
        instr <= {6'h00, 5'd1, 5'd2, 5'd3, 5'd0, 6'h21};
        instr_valid <= 1'b1;
        have_pending = 1'b0;
        reset_behavior();
        special_ops();
        immediate_ops();
        branch_ops();
        reserved_ops();
        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0)
            $display("TEST RESULT: PASS");
        else
            $display("TEST RESULT: FAIL");
        $finish;
    end

endmodule

// ==== tb/tb_clock.sv ====
`timescale 1ns/1ps

module tb_clock #(
    parameter int PERIOD_NS    = 20,
    parameter int RESET_CYCLES = 8
) (
    output logic clk,
    output logic rst_n
);

    initial begin
        clk = 1'b0;
        forever #(PERIOD_NS / 2) clk = ~clk;
    end

    // Released on a rising edge so the DUT sees a whole cycle of reset
    initial begin
        rst_n <= 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        rst_n <= 1'b1;
    end

endmodule

// ==== src/decode_stage.sv ====
`timescale 1ns/1ps
`include "mips_defs.svh"

module decode_stage
    import isa_pkg::*;
    import decode_pkg::*;
(
    input  logic           clk,
    input  logic           rst_n,
    input  word_t          instr,
    input  logic           instr_valid,
    output decode_result_t dec,
    output logic           dec_valid
);

    opcode_e        opcode;
    funct_e         funct;
    regimm_e        regimm;
    reg_addr_t      rs;
    reg_addr_t      rt;
    reg_addr_t      rd;
    decode_result_t special_res;
    decode_result_t imm_res;
    decode_result_t branch_res;
    decode_result_t next_dec;
    logic           special_hit;
    logic           imm_hit;
    logic           branch_hit;

    assign opcode = opcode_e'(instr[`OPCODE_HI:`OPCODE_LO]);
    assign funct  = funct_e'(instr[`FUNCT_HI:`FUNCT_LO]);
    assign regimm = regimm_e'(instr[`RT_HI:`RT_LO]);
    assign rs     = instr[`RS_HI:`RS_LO];
    assign rt     = instr[`RT_HI:`RT_LO];
    assign rd     = instr[`RD_HI:`RD_LO];

    special_decode u_special (
        .opcode (opcode),
        .funct  (funct),
        .rs     (rs),
        .rt     (rt),
        .rd     (rd),
        .res    (special_res),
        .hit    (special_hit)
    );

    imm_decode u_imm (
        .opcode (opcode),
        .rs     (rs),
        .rt     (rt),
        .res    (imm_res),
        .hit    (imm_hit)
    );

    branch_decode u_branch (
        .opcode (opcode),
        .regimm (regimm),
        .rs     (rs),
        .rt     (rt),
        .res    (branch_res),
        .hit    (branch_hit)
    );

    // Sub-decoders drive zero when they miss, so OR is enough to merge
    always_comb begin
        next_dec = decode_result_t'(special_res | imm_res | branch_res);
        if (!(special_hit || imm_hit || branch_hit)) begin
            next_dec = '0;
            next_dec.op = RESERVED;
            next_dec.ctl.alufunc = ALU_PASSA;
            next_dec.exception_ri = 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            dec <= '0;
            dec_valid <= 1'b0;
        end else begin
            dec_valid <= instr_valid;
            if (instr_valid) begin
                dec <= next_dec;
            end
        end
    end

    // Opcode ownership of the sub-decoders must not overlap
    a_one_owner: assert property (@(posedge clk) disable iff (!rst_n)
        $onehot0({special_hit, imm_hit, branch_hit}));

    a_ri_no_write: assert property (@(posedge clk) disable iff (!rst_n)
        dec_valid && dec.exception_ri |-> !dec.ctl.regwrite && !dec.ctl.memwrite);

    a_reset_idle: assert property (@(posedge clk) !rst_n |=> !dec_valid);

endmodule

// ==== src/branch_decode.sv ====
`timescale 1ns/1ps
`include "mips_defs.svh"

module branch_decode
    import isa_pkg::*;
    import decode_pkg::*;
(
    input  opcode_e        opcode,
    input  regimm_e        regimm,
    input  reg_addr_t      rs,
    input  reg_addr_t      rt,
    output decode_result_t res,
    output logic           hit
);

    decoded_op_e  op;
    branch_type_e btype;
    logic         two_reg;
    logic         abs_jump;
    logic         link;

    always_comb begin
        case (opcode)
            OP_BEQ:  op = BEQ;
            OP_BNE:  op = BNE;
            OP_BGTZ: op = BGTZ;
            OP_BLEZ: op = BLEZ;
            OP_J:    op = J;
            OP_JAL:  op = JAL;
            OP_REGIMM: begin
                case (regimm)
                    RI_BGEZ:   op = BGEZ;
                    RI_BLTZ:   op = BLTZ;
                    RI_BGEZAL: op = BGEZAL;
                    RI_BLTZAL: op = BLTZAL;
                    default:   op = RESERVED;
                endcase
            end
            default: op = RESERVED;
        endcase
    end

    // Linking forms test the same condition as the plain ones
    always_comb begin
        case (op)
            BEQ:            btype = T_BEQ;
            BNE:            btype = T_BNE;
            BGEZ, BGEZAL:   btype = T_BGEZ;
            BLTZ, BLTZAL:   btype = T_BLTZ;
            BGTZ:           btype = T_BGTZ;
            BLEZ:           btype = T_BLEZ;
            default:        btype = T_NONE;
        endcase
    end

    assign two_reg  = op inside {BEQ, BNE};
    assign abs_jump = op inside {J, JAL};
    assign link     = op inside {BGEZAL, BLTZAL, JAL};
    assign hit      = (op != RESERVED);

    always_comb begin
        res = '0;
        if (hit) begin
            res.op = op;
            res.srcrega = abs_jump ? '0 : rs;
            res.srcregb = two_reg ? rt : '0;
            res.destreg = link ? reg_addr_t'(`LINK_REG) : '0;
            res.ctl.branch = !abs_jump;
            res.ctl.branch1 = !abs_jump && !two_reg;
            res.ctl.branch2 = two_reg;
            res.ctl.branch_type = btype;
            res.ctl.jump = abs_jump;
            res.ctl.regwrite = link;
            res.ctl.is_link = link;
        end
    end

endmodule

// ==== src/imm_decode.sv ====
`timescale 1ns/1ps

module imm_decode
    import isa_pkg::*;
    import decode_pkg::*;
(
    input  opcode_e        opcode,
    input  reg_addr_t      rs,
    input  reg_addr_t      rt,
    output decode_result_t res,
    output logic           hit
);

    decoded_op_e op;
    logic        is_load;
    logic        is_store;

    always_comb begin
        case (opcode)
            OP_ADDI:  op = ADDI;
            OP_ADDIU: op = ADDIU;
            OP_SLTI:  op = SLTI;
            OP_SLTIU: op = SLTIU;
            OP_ANDI:  op = ANDI;
            OP_ORI:   op = ORI;
            OP_XORI:  op = XORI;
            OP_LUI:   op = LUI;
            OP_LB:    op = LB;
            OP_LBU:   op = LBU;
            OP_LH:    op = LH;
            OP_LHU:   op = LHU;
            OP_LW:    op = LW;
            OP_SB:    op = SB;
            OP_SH:    op = SH;
            OP_SW:    op = SW;
            default:  op = RESERVED;
        endcase
    end

    assign is_load  = op inside {LB, LBU, LH, LHU, LW};
    assign is_store = op inside {SB, SH, SW};
    assign hit      = (op != RESERVED);

    always_comb begin
        res = '0;
        if (hit) begin
            res.op = op;
            res.ctl.alusrc = IMM;
            // LUI ignores rs
            res.srcrega = (op == LUI) ? '0 : rs;
            if (is_store) begin
                res.srcregb = rt;
                res.ctl.memwrite = 1'b1;
            end else begin
                res.destreg = rt;
                res.ctl.regwrite = 1'b1;
                if (is_load) begin
                    res.ctl.memtoreg = 1'b1;
                end else begin
                    res.ctl.alufunc = alu_func_of(op);
                    // Logical immediates are zero extended
                    res.ctl.zeroext = op inside {ANDI, ORI, XORI};
                    res.ctl.delayen = (op != ADDI);
                end
            end
        end
    end

endmodule

// ==== src/special_decode.sv ====
`timescale 1ns/1ps
`include "mips_defs.svh"

module special_decode
    import isa_pkg::*;
    import decode_pkg::*;
(
    input  opcode_e        opcode,
    input  funct_e         funct,
    input  reg_addr_t      rs,
    input  reg_addr_t      rt,
    input  reg_addr_t      rd,
    output decode_result_t res,
    output logic           hit
);

    decoded_op_e op;
    logic        const_shift;
    logic        reg_jump;

    always_comb begin
        case (funct)
            F_ADD:   op = ADD;
            F_ADDU:  op = ADDU;
            F_SUB:   op = SUB;
            F_SUBU:  op = SUBU;
            F_SLT:   op = SLT;
            F_SLTU:  op = SLTU;
            F_AND:   op = AND;
            F_OR:    op = OR;
            F_XOR:   op = XOR;
            F_NOR:   op = NOR;
            F_SLL:   op = SLL;
            F_SRL:   op = SRL;
            F_SRA:   op = SRA;
            F_SLLV:  op = SLLV;
            F_SRLV:  op = SRLV;
            F_SRAV:  op = SRAV;
            F_JR:    op = JR;
            F_JALR:  op = JALR;
            default: op = RESERVED;
        endcase
    end

    // Constant shifts take the amount from shamt, not from rs
    assign const_shift = op inside {SLL, SRL, SRA};
    assign reg_jump    = op inside {JR, JALR};
    assign hit         = (opcode == OP_SPECIAL) && (op != RESERVED);

    always_comb begin
        res = '0;
        if (hit) begin
            res.op = op;
            res.ctl.alufunc = alu_func_of(op);
            res.srcrega = const_shift ? '0 : rs;
            if (reg_jump) begin
                res.ctl.jump = 1'b1;
                res.ctl.jr = 1'b1;
                if (op == JALR) begin
                    res.ctl.regwrite = 1'b1;
                    res.ctl.is_link = 1'b1;
                    res.destreg = reg_addr_t'(`LINK_REG);
                end
            end else begin
                res.srcregb = rt;
                res.destreg = rd;
                res.ctl.alusrc = REGB;
                res.ctl.regwrite = 1'b1;
                res.ctl.shamt_valid = const_shift;
                // Trapping add and subtract excluded
                res.ctl.delayen = !(op inside {ADD, SUB});
            end
        end
    end

endmodule

// ==== src/decode_pkg.sv ====
package decode_pkg;

    import isa_pkg::*;

    // Zero is kept for RESERVED so an idle result carries no operation
    typedef enum logic [5:0] {
        RESERVED = 6'd0,
        ADD, ADDU, SUB, SUBU, SLT, SLTU, AND, OR, XOR, NOR,
        SLL, SRL, SRA, SLLV, SRLV, SRAV,
        JR, JALR,
        ADDI, ADDIU, SLTI, SLTIU, ANDI, ORI, XORI, LUI,
        BEQ, BNE, BGEZ, BLTZ, BGEZAL, BLTZAL, BGTZ, BLEZ,
        J, JAL,
        LB, LBU, LH, LHU, LW, SB, SH, SW
    } decoded_op_e;

    typedef enum logic [3:0] {
        ALU_PASSA = 4'd0,
        ALU_ADD, ALU_ADDU, ALU_SUB, ALU_SUBU, ALU_SLT, ALU_SLTU,
        ALU_AND, ALU_OR, ALU_XOR, ALU_NOR,
        ALU_SLL, ALU_SRL, ALU_SRA, ALU_LUI
    } alu_func_e;

    typedef enum logic [2:0] {
        T_NONE = 3'd0,
        T_BEQ, T_BNE, T_BGEZ, T_BLTZ, T_BGTZ, T_BLEZ
    } branch_type_e;

    typedef enum logic {
        REGB = 1'b0,
        IMM  = 1'b1
    } alu_src_e;

    typedef struct packed {
        alu_func_e    alufunc;
        alu_src_e     alusrc;
        logic         regwrite;
        logic         memtoreg;
        logic         memwrite;
        logic         zeroext;
        logic         shamt_valid;
        logic         delayen;
        logic         branch;
        logic         branch1;
        logic         branch2;
        branch_type_e branch_type;
        logic         jump;
        logic         jr;
        logic         is_link;
    } control_t;

    typedef struct packed {
        decoded_op_e op;
        control_t    ctl;
        reg_addr_t   srcrega;
        reg_addr_t   srcregb;
        reg_addr_t   destreg;
        logic        exception_ri;
    } decode_result_t;

    // Register and immediate forms share one ALU operation
    function automatic alu_func_e alu_func_of(decoded_op_e op);
        alu_func_e f;
        case (op)
            ADD, ADDI:   f = ALU_ADD;
            ADDU, ADDIU: f = ALU_ADDU;
            SUB:         f = ALU_SUB;
            SUBU:        f = ALU_SUBU;
            SLT, SLTI:   f = ALU_SLT;
            SLTU, SLTIU: f = ALU_SLTU;
            AND, ANDI:   f = ALU_AND;
            OR, ORI:     f = ALU_OR;
            XOR, XORI:   f = ALU_XOR;
            NOR:         f = ALU_NOR;
            SLL, SLLV:   f = ALU_SLL;
            SRL, SRLV:   f = ALU_SRL;
            SRA, SRAV:   f = ALU_SRA;
            LUI:         f = ALU_LUI;
            default:     f = ALU_PASSA;
        endcase
        return f;
    endfunction

endpackage

// ==== src/isa_pkg.sv ====
`include "mips_defs.svh"

package isa_pkg;

    typedef logic [`WORD_W-1:0]     word_t;
    typedef logic [`REG_ADDR_W-1:0] reg_addr_t;

    // Primary opcodes that are decoded, everything else is reserved
    typedef enum logic [5:0] {
        OP_SPECIAL = 6'b000000,
        OP_REGIMM  = 6'b000001,
        OP_J       = 6'b000010,
        OP_JAL     = 6'b000011,
        OP_BEQ     = 6'b000100,
        OP_BNE     = 6'b000101,
        OP_BLEZ    = 6'b000110,
        OP_BGTZ    = 6'b000111,
        OP_ADDI    = 6'b001000,
        OP_ADDIU   = 6'b001001,
        OP_SLTI    = 6'b001010,
        OP_SLTIU   = 6'b001011,
        OP_ANDI    = 6'b001100,
        OP_ORI     = 6'b001101,
        OP_XORI    = 6'b001110,
        OP_LUI     = 6'b001111,
        OP_LB      = 6'b100000,
        OP_LH      = 6'b100001,
        OP_LW      = 6'b100011,
        OP_LBU     = 6'b100100,
        OP_LHU     = 6'b100101,
        OP_SB      = 6'b101000,
        OP_SH      = 6'b101001,
        OP_SW      = 6'b101011
    } opcode_e;

    // SPECIAL function field
    typedef enum logic [5:0] {
        F_SLL  = 6'b000000,
        F_SRL  = 6'b000010,
        F_SRA  = 6'b000011,
        F_SLLV = 6'b000100,
        F_SRLV = 6'b000110,
        F_SRAV = 6'b000111,
        F_JR   = 6'b001000,
        F_JALR = 6'b001001,
        F_ADD  = 6'b100000,
        F_ADDU = 6'b100001,
        F_SUB  = 6'b100010,
        F_SUBU = 6'b100011,
        F_AND  = 6'b100100,
        F_OR   = 6'b100101,
        F_XOR  = 6'b100110,
        F_NOR  = 6'b100111,
        F_SLT  = 6'b101010,
        F_SLTU = 6'b101011
    } funct_e;

    // REGIMM group, selected by the rt field
    typedef enum logic [4:0] {
        RI_BLTZ   = 5'b00000,
        RI_BGEZ   = 5'b00001,
        RI_BLTZAL = 5'b10000,
        RI_BGEZAL = 5'b10001
    } regimm_e;

endpackage

// ==== include/mips_defs.svh ====
`ifndef MIPS_DEFS_SVH
`define MIPS_DEFS_SVH

// Datapath widths
`define WORD_W      32
`define REG_ADDR_W  5

// Return address register for JAL, JALR and the linking REGIMM branches
`define LINK_REG    31

// Instruction field positions
`define OPCODE_HI   31
`define OPCODE_LO   26
`define RS_HI       25
`define RS_LO       21
`define RT_HI       20
`define RT_LO       16
`define RD_HI       15
`define RD_LO       11
`define SHAMT_HI    10
`define SHAMT_LO    6
`define FUNCT_HI    5
`define FUNCT_LO    0

`endif
